// File: pipeDatapath.f
source/riscvPkg.sv
source/regFile.sv
source/aluCore.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/pipeDatapath.sv
sim/tbPipeDatapath.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tbPipeDatapath \
    -f pipeDatapath.f -o tbSim &&
./obj_dir/tbSim | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run.sh: testbench reported success" ||
{ echo "run.sh: testbench reported failure or did not build"; exit 1; }

// File: sim/tbPipeDatapath.sv
`timescale 1ns/1ps

module tbPipeDatapath;
    import riscvPkg::*;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } brResultT;

    logic              clk = 1'b0;
    logic              reset_i;
    logic              instrValid_i;
    instrWordT         instr_i;
    logic [xlen-1:0]   pc_i;
    logic              decodeEnable_i;
    logic              decodeFlush_i;
    wbPortT            wbPort_o;
    logic              branchTaken_o;
    logic [xlen-1:0]   branchTarget_o;
    logic [xlen-1:0]   a0_o;

    int          seed = 32'h86f4214b;
    int          cycleCount = 0;
    int          lastDue = 0;
    int          failCount = 0;
    int          passTests = 0;
    int          failTests = 0;
    logic        flushNext = 1'b0;
    logic [31:0] pcVal = '0;
    logic [31:0] mdlRegs [32];
    logic [31:0] mdlMem [64];
    wbPortT      expWb [4096];  // indexed by cycleCount at the sampling edge
    brResultT    expBr [4096];

    // immediate ALU forms other than shifts
    logic [2:0] f3List [6] = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};

    pipeDatapath #(.dmemDepth(64)) i_dut (
        .clk            (clk),
        .reset_i        (reset_i),
        .instrValid_i   (instrValid_i),
        .instr_i        (instr_i),
        .pc_i           (pc_i),
        .decodeEnable_i (decodeEnable_i),
        .decodeFlush_i  (decodeFlush_i),
        .wbPort_o       (wbPort_o),
        .branchTaken_o  (branchTaken_o),
        .branchTarget_o (branchTarget_o),
        .a0_o           (a0_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) cycleCount <= cycleCount + 1;

    wbMatches: assert property (@(posedge clk) disable iff (reset_i)
        wbPort_o.valid == expWb[cycleCount].valid &&
        (!wbPort_o.valid || (wbPort_o.rd == expWb[cycleCount].rd &&
                             wbPort_o.data == expWb[cycleCount].data)))
        else begin
            failCount++;
            $display("Fail at %0t: writeback got %h, expected %h", $time, wbPort_o,
                     expWb[cycleCount]);
        end

    branchMatches: assert property (@(posedge clk) disable iff (reset_i)
        branchTaken_o == expBr[cycleCount].taken &&
        (!branchTaken_o || branchTarget_o == expBr[cycleCount].target))
        else begin
            failCount++;
            $display("Fail at %0t: branch got %b/%h, expected %b/%h", $time, branchTaken_o,
                     branchTarget_o, expBr[cycleCount].taken, expBr[cycleCount].target);
        end

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    function automatic logic [11:0] randImm12();
        logic [31:0] r;
        r = $random(seed);
        return r[11:0];
    endfunction

    function automatic logic [19:0] randImm20();
        logic [31:0] r;
        r = $random(seed);
        return r[19:0];
    endfunction

    function automatic logic [4:0] regPick();  // x1..x9
        logic [31:0] r;
        r = $random(seed);
        return 5'(1 + r[15:0] % 9);
    endfunction

    // RV32I integer semantics
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'd0, $signed(a) < $signed(b)};
            3'b011: return {31'd0, a < b};
            3'b100: return a ^ b;
            3'b101: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic modelExec(input logic [31:0] w, input logic [31:0] pc,
                             output wbPortT wb, output brResultT br);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] addr;
        a    = mdlRegs[w[19:15]];
        b    = mdlRegs[w[24:20]];
        immI = {{20{w[31]}}, w[31:20]};
        immS = {{20{w[31]}}, w[31:25], w[11:7]};
        wb   = '0;
        br   = '0;
        wb.rd = w[11:7];
        case (w[6:0])
            7'b0110011: wb = {1'b1, w[11:7], aluRef(w[14:12], w[30], a, b)};
            7'b0010011: wb = {1'b1, w[11:7], aluRef(w[14:12], w[30] && w[14:12] == 3'b101,
                                                    a, immI)};
            7'b0000011: begin
                addr = a + immI;
                wb   = {1'b1, w[11:7], mdlMem[addr[7:2]]};
            end
            7'b0100011: begin
                addr = a + immS;
                mdlMem[addr[7:2]] = b;
            end
            7'b1100011: begin
                br.taken  = w[12] ? (a != b) : (a == b);
                br.target = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            7'b1101111: begin
                br = {1'b1, pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0}};
                wb = {1'b1, w[11:7], pc + 32'd4};
            end
            7'b1100111: begin
                addr = a + immI;
                br   = {1'b1, addr[31:1], 1'b0};
                wb   = {1'b1, w[11:7], pc + 32'd4};
            end
            default: wb.valid = 1'b0;
        endcase
        if (wb.rd == 5'd0) begin
            wb.valid = 1'b0;  // x0 never shows up
        end else if (wb.valid) begin
            mdlRegs[wb.rd] = wb.data;
        end
    endtask

    // wrong-path slot after a taken branch gets flushed
    task automatic issue(input logic [31:0] word, input logic flushIt, input logic holdIt);
        wbPortT   wb;
        brResultT br;
        int       idx;
        logic     dropIt;
        @(posedge clk);
        idx    = cycleCount;
        dropIt = flushIt || flushNext;
        instrValid_i   <= 1'b1;
        instr_i        <= word;
        pc_i           <= pcVal;
        decodeFlush_i  <= dropIt;
        decodeEnable_i <= !holdIt;
        flushNext = 1'b0;
        if (!dropIt) begin
            modelExec(word, pcVal, wb, br);
            expWb[idx + 4] = wb;
            expBr[idx + 2] = br;
            lastDue   = idx + 4;
            pcVal     = br.taken ? br.target : pcVal + 32'd4;
            flushNext = br.taken;
        end
    endtask

    task automatic idleSlot();
        @(posedge clk);
        instrValid_i   <= 1'b0;
        decodeFlush_i  <= 1'b0;
        decodeEnable_i <= 1'b1;
        flushNext = 1'b0;
    endtask

    task automatic drainPipe();
        int waited;
        waited = 0;
        idleSlot();
        while (cycleCount <= lastDue + 1 && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= 50) begin
            failCount++;
            $display("Timed out at %0t while waiting for the pipeline to drain", $time);
        end
    endtask

    task automatic finishTest(input string name, input int errsBefore);
        if (failCount == errsBefore) begin
            passTests++;
            $display("test %s passed", name);
        end else begin
            failTests++;
            $display("test %s failed with %0d errors", name, failCount - errsBefore);
        end
    endtask

    initial begin : watchdog
        #200000;
        $display("The run did not finish within 2000 clock cycles");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : mainSeq
        int          errs;
        logic [31:0] r;
        logic [2:0]  f3;
        logic [11:0] addrImm;
        reset_i        = 1'b1;
        instrValid_i   = 1'b0;
        instr_i        = '0;
        pc_i           = '0;
        decodeEnable_i = 1'b1;
        decodeFlush_i  = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            expWb[i] = '0;
            expBr[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            mdlRegs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mdlMem[i] = '0;
        end
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;

        errs = failCount;
        for (int i = 1; i <= 4; i++) begin
            issue(encI(randImm12(), 5'd0, 3'b000, 5'(i), 7'b0010011), 1'b0, 1'b0);
        end
        for (int f = 0; f < 8; f++) begin
            issue(encR(7'h00, 5'd2, 5'd1, 3'(f), 5'(5 + f)), 1'b0, 1'b0);
        end
        issue(encR(7'h20, 5'd2, 5'd1, 3'b000, 5'd13), 1'b0, 1'b0);  // sub
        issue(encR(7'h20, 5'd4, 5'd3, 3'b101, 5'd14), 1'b0, 1'b0);  // sra
        foreach (f3List[k]) begin
            issue(encI(randImm12(), 5'd3, f3List[k], 5'(5 + k), 7'b0010011), 1'b0, 1'b0);
        end
        r = randWord();
        issue(encI({7'h00, r[4:0]}, 5'd4, 3'b001, 5'd11, 7'b0010011), 1'b0, 1'b0);
        issue(encI({7'h00, r[9:5]}, 5'd4, 3'b101, 5'd12, 7'b0010011), 1'b0, 1'b0);
        issue(encI({7'h20, r[14:10]}, 5'd4, 3'b101, 5'd13, 7'b0010011), 1'b0, 1'b0);
        issue(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd0), 1'b0, 1'b0);  // lands in x0
        drainPipe();
        finishTest("alu ops", errs);

        // dependent chains one and two slots apart
        errs = failCount;
        for (int i = 0; i < 24; i++) begin
            r  = randWord();
            f3 = r[2:0];
            issue(encR((f3 == 3'b000 || f3 == 3'b101) && r[3] ? 7'h20 : 7'h00,
                       regPick(), regPick(), f3, regPick()), 1'b0, 1'b0);
        end
        drainPipe();
        finishTest("forwarding", errs);

        errs = failCount;
        for (int k = 0; k < 4; k++) begin
            r       = randWord();
            addrImm = {4'd0, r[5:0], 2'b00};
            issue(encS(addrImm, regPick(), 5'd0), 1'b0, 1'b0);
            issue(encI(addrImm, 5'd0, 3'b010, 5'(11 + k), 7'b0000011), 1'b0, 1'b0);
            idleSlot();
            issue(encR(7'h00, 5'd1, 5'(11 + k), 3'b000, 5'(16 + k)), 1'b0, 1'b0);
        end
        drainPipe();
        finishTest("load store", errs);

        // the slot after each possible redirect is flushed when taken
        errs = failCount;
        issue(encB({randImm12(), 1'b0}, 5'd1, 5'd1, 3'b000), 1'b0, 1'b0);
        issue(encI(12'd5, 5'd0, 3'b000, 5'd20, 7'b0010011), 1'b0, 1'b0);
        issue(encB({randImm12(), 1'b0}, 5'd1, 5'd1, 3'b001), 1'b0, 1'b0);
        issue(encI(12'd6, 5'd0, 3'b000, 5'd20, 7'b0010011), 1'b0, 1'b0);
        issue(encB({randImm12(), 1'b0}, 5'd2, 5'd1, 3'b001), 1'b0, 1'b0);
        issue(encI(12'd7, 5'd0, 3'b000, 5'd20, 7'b0010011), 1'b0, 1'b0);
        issue(encJ({randImm20(), 1'b0}, 5'd21), 1'b0, 1'b0);
        issue(encI(12'd8, 5'd0, 3'b000, 5'd20, 7'b0010011), 1'b0, 1'b0);
        issue(encI(randImm12(), 5'd3, 3'b000, 5'd3, 7'b0010011), 1'b0, 1'b0);
        issue(encI(randImm12(), 5'd3, 3'b000, 5'd22, 7'b1100111), 1'b0, 1'b0);
        issue(encR(7'h00, 5'd22, 5'd21, 3'b000, 5'd23), 1'b0, 1'b0);
        issue(encB({randImm12(), 1'b0}, 5'd5, 5'd4, 3'b000), 1'b0, 1'b0);
        issue(encR(7'h00, 5'd23, 5'd22, 3'b100, 5'd24), 1'b0, 1'b0);
        drainPipe();
        finishTest("branches", errs);

        errs = failCount;
        issue(encI(12'h123, 5'd0, 3'b000, 5'd25, 7'b0010011), 1'b1, 1'b0);
        issue(encI(12'h456, 5'd0, 3'b000, 5'd26, 7'b0010011), 1'b1, 1'b1);
        issue(encB(13'd16, 5'd0, 5'd0, 3'b000), 1'b1, 1'b0);
        issue(encI(12'h07f, 5'd0, 3'b000, 5'd25, 7'b0010011), 1'b0, 1'b0);
        issue(encR(7'h00, 5'd25, 5'd25, 3'b000, 5'd26), 1'b0, 1'b0);
        drainPipe();
        finishTest("flush", errs);

        errs = failCount;
        issue(encI(randImm12(), 5'd3, 3'b000, 5'd10, 7'b0010011), 1'b0, 1'b0);
        issue(encR(7'h00, 5'd16, 5'd10, 3'b000, 5'd10), 1'b0, 1'b0);
        drainPipe();
        a0Final: assert (a0_o == mdlRegs[10])
            else begin
                failCount++;
                $display("Fail at %0t: a0 is %h, expected %h", $time, a0_o, mdlRegs[10]);
            end
        finishTest("final a0", errs);

        $display("tests passed: %0d, tests failed: %0d", passTests, failTests);
        if (failCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: source/pipeDatapath.sv
`timescale 1ns/1ps

module pipeDatapath #(
    parameter int dmemDepth = 64
) (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      instrValid_i,
    input  riscvPkg::instrWordT       instr_i,
    input  logic [riscvPkg::xlen-1:0] pc_i,
    input  logic                      decodeEnable_i,
    input  logic                      decodeFlush_i,
    output riscvPkg::wbPortT          wbPort_o,
    output logic                      branchTaken_o,
    output logic [riscvPkg::xlen-1:0] branchTarget_o,
    output logic [riscvPkg::xlen-1:0] a0_o
);
    import riscvPkg::*;

    idExT   idEx;
    exMemT  exMem;
    wbPortT wbPort;

    decodeStage i_decodeStage (
        .clk            (clk),
        .reset_i        (reset_i),
        .instrValid_i   (instrValid_i),
        .instr_i        (instr_i),
        .pc_i           (pc_i),
        .decodeEnable_i (decodeEnable_i),
        .decodeFlush_i  (decodeFlush_i),
        .wbPort_i       (wbPort),
        .idEx_o         (idEx),
        .a0_o           (a0_o)
    );

    executeStage i_executeStage (
        .clk            (clk),
        .reset_i        (reset_i),
        .idEx_i         (idEx),
        .wbPort_i       (wbPort),
        .exMem_o        (exMem),
        .branchTaken_o  (branchTaken_o),
        .branchTarget_o (branchTarget_o)
    );

    memoryStage #(
        .dmemDepth (dmemDepth)
    ) i_memoryStage (
        .clk      (clk),
        .reset_i  (reset_i),
        .exMem_i  (exMem),
        .wbPort_o (wbPort)
    );

    assign wbPort_o = wbPort;

endmodule

// File: source/memoryStage.sv
`timescale 1ns/1ps

module memoryStage #(
    parameter int dmemDepth = 64
) (
    input  logic             clk,
    input  logic             reset_i,
    input  riscvPkg::exMemT  exMem_i,
    output riscvPkg::wbPortT wbPort_o
);
    import riscvPkg::*;

    localparam int addrBits = $clog2(dmemDepth);

    typedef struct packed {
        logic            regWrite;
        logic [4:0]      rd;
        resultSrcE       resultSrc;
        logic [xlen-1:0] aluResult;
        logic [xlen-1:0] loadData;
        logic [xlen-1:0] pcPlus4;
    } memWbT;

    logic [xlen-1:0]     dmem [dmemDepth];
    logic [addrBits-1:0] wordAddr;
    logic [xlen-1:0]     loadData;
    memWbT               memWbQ;
    logic                validQ;

    assign wordAddr = exMem_i.aluResult[addrBits+1:2];  // word index
    assign loadData = dmem[wordAddr];

    always_ff @(posedge clk) begin
        if (exMem_i.valid && exMem_i.memWrite) begin
            dmem[wordAddr] <= exMem_i.storeData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            validQ <= 1'b0;
        end else begin
            validQ <= exMem_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        memWbQ.regWrite  <= exMem_i.regWrite;
        memWbQ.rd        <= exMem_i.rd;
        memWbQ.resultSrc <= exMem_i.resultSrc;
        memWbQ.aluResult <= exMem_i.aluResult;
        memWbQ.loadData  <= loadData;
        memWbQ.pcPlus4   <= exMem_i.pcPlus4;
    end

    always_comb begin
        wbPort_o.valid = validQ && memWbQ.regWrite;
        wbPort_o.rd    = memWbQ.rd;
        case (memWbQ.resultSrc)
            resMem:  wbPort_o.data = memWbQ.loadData;
            resPc4:  wbPort_o.data = memWbQ.pcPlus4;  // jal/jalr link
            default: wbPort_o.data = memWbQ.aluResult;
        endcase
    end

    // only whole words are supported
    wordAligned: assert property (@(posedge clk) disable iff (reset_i)
        exMem_i.valid && (exMem_i.memWrite || exMem_i.resultSrc == resMem)
        |-> exMem_i.aluResult[1:0] == 2'b00)
        else $error("misaligned data memory access");

endmodule

// File: source/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic                      clk,
    input  logic                      reset_i,
    input  riscvPkg::idExT            idEx_i,
    input  riscvPkg::wbPortT          wbPort_i,
    output riscvPkg::exMemT           exMem_o,
    output logic                      branchTaken_o,
    output logic [riscvPkg::xlen-1:0] branchTarget_o
);
    import riscvPkg::*;

    logic [xlen-1:0] memFwdData;
    logic            memFwdOk;
    logic [xlen-1:0] srcA;
    logic [xlen-1:0] rs2Fwd;
    logic [xlen-1:0] srcB;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] pcPlus4;
    logic            zero;
    logic            condMet;
    exMemT           exMemD;
    exMemT           payloadQ;
    logic            validQ;

    // memory stage first, then writeback, then the decoded value
    function automatic logic [xlen-1:0] forwardSel(input logic [4:0] rs,
                                                   input logic [xlen-1:0] decoded);
        if (rs == 5'd0) begin
            return decoded;
        end
        if (memFwdOk && exMem_o.rd == rs) begin
            return memFwdData;
        end
        if (wbPort_i.valid && wbPort_i.rd == rs) begin
            return wbPort_i.data;
        end
        return decoded;
    endfunction

    // loads are not ready until writeback
    assign memFwdOk = exMem_o.valid && exMem_o.regWrite && exMem_o.rd != 5'd0 &&
                      exMem_o.resultSrc != resMem;
    assign memFwdData = (exMem_o.resultSrc == resPc4) ? exMem_o.pcPlus4 : exMem_o.aluResult;

    always_comb begin
        srcA   = forwardSel(idEx_i.rs1, idEx_i.rs1Data);
        rs2Fwd = forwardSel(idEx_i.rs2, idEx_i.rs2Data);
    end

    assign srcB    = idEx_i.aluSrcImm ? idEx_i.imm : rs2Fwd;
    assign pcPlus4 = idEx_i.pc + 32'd4;

    aluCore i_aluCore (
        .op_i     (idEx_i.aluOp),
        .srcA_i   (srcA),
        .srcB_i   (srcB),
        .result_o (aluResult),
        .zero_o   (zero)
    );

    assign condMet       = zero ^ idEx_i.branchNe;  // inverted for bne
    assign branchTaken_o = idEx_i.valid && ((idEx_i.branch && condMet) || idEx_i.jump);
    assign branchTarget_o = idEx_i.jalr ? {aluResult[xlen-1:1], 1'b0}
                                        : idEx_i.pc + idEx_i.imm;

    always_comb begin
        exMemD.valid     = idEx_i.valid;
        exMemD.aluResult = aluResult;
        exMemD.storeData = rs2Fwd;
        exMemD.rd        = idEx_i.rd;
        exMemD.regWrite  = idEx_i.regWrite;
        exMemD.memWrite  = idEx_i.memWrite;
        exMemD.resultSrc = idEx_i.resultSrc;
        exMemD.pcPlus4   = pcPlus4;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            validQ <= 1'b0;
        end else begin
            validQ <= exMemD.valid;
        end
    end

    always_ff @(posedge clk) begin
        payloadQ <= exMemD;
    end

    always_comb begin
        exMem_o       = payloadQ;
        exMem_o.valid = validQ;
    end

    // a flushed or empty slot never redirects fetch
    noBranchOnBubble: assert property (@(posedge clk) disable iff (reset_i)
        !idEx_i.valid |-> !branchTaken_o)
        else $error("branch taken from an invalid execute slot");

endmodule

// File: source/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      instrValid_i,
    input  riscvPkg::instrWordT       instr_i,
    input  logic [riscvPkg::xlen-1:0] pc_i,
    input  logic                      decodeEnable_i,
    input  logic                      decodeFlush_i,
    input  riscvPkg::wbPortT          wbPort_i,
    output riscvPkg::idExT            idEx_o,
    output logic [riscvPkg::xlen-1:0] a0_o
);
    import riscvPkg::*;

    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;
    logic [xlen-1:0] immJ;
    logic            known;
    idExT            dec;
    idExT            payloadQ;
    logic            validQ;

    function automatic aluOpE aluDecode(input logic [2:0] funct3, input logic alt,
                                        input logic isReg);
        case (funct3)
            3'b000: return (isReg && alt) ? aluSub : aluAdd;
            3'b001: return aluSll;
            3'b010: return aluSlt;
            3'b011: return aluSltu;
            3'b100: return aluXor;
            3'b101: return alt ? aluSra : aluSrl;
            3'b110: return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    regFile i_regFile (
        .clk       (clk),
        .reset_i   (reset_i),
        .rs1_i     (instr_i.rView.rs1),
        .rs2_i     (instr_i.rView.rs2),
        .wr_i      (wbPort_i),
        .rs1Data_o (rs1Data),
        .rs2Data_o (rs2Data),
        .a0_o      (a0_o)
    );

    assign immI = {{20{instr_i.iView.imm[11]}}, instr_i.iView.imm};
    assign immS = {{20{instr_i.sView.immHi[6]}}, instr_i.sView.immHi, instr_i.sView.immLo};
    assign immB = {{20{instr_i.bView.imm12}}, instr_i.bView.imm11, instr_i.bView.immMid,
                   instr_i.bView.immLo, 1'b0};
    // J layout sits on the R-type fields
    assign immJ = {{12{instr_i.rView.funct7[6]}}, instr_i.rView.rs1, instr_i.rView.funct3,
                   instr_i.rView.rs2[0], instr_i.rView.funct7[5:0], instr_i.rView.rs2[4:1],
                   1'b0};

    always_comb begin
        dec           = '0;
        dec.pc        = pc_i;
        dec.rs1       = instr_i.rView.rs1;
        dec.rs2       = instr_i.rView.rs2;
        dec.rd        = instr_i.rView.rd;
        dec.rs1Data   = rs1Data;
        dec.rs2Data   = rs2Data;
        dec.aluOp     = aluAdd;
        dec.resultSrc = resAlu;
        known         = 1'b1;
        case (instr_i.rView.opcode)
            opReg: begin
                dec.aluOp    = aluDecode(instr_i.rView.funct3, instr_i.rView.funct7[5], 1'b1);
                dec.regWrite = 1'b1;
            end
            opImm: begin
                dec.aluOp     = aluDecode(instr_i.rView.funct3, instr_i.rView.funct7[5], 1'b0);
                dec.aluSrcImm = 1'b1;
                dec.imm       = immI;
                dec.regWrite  = 1'b1;
            end
            opLoad: begin
                dec.aluSrcImm = 1'b1;
                dec.imm       = immI;
                dec.regWrite  = 1'b1;
                dec.resultSrc = resMem;
            end
            opStore: begin
                dec.aluSrcImm = 1'b1;
                dec.imm       = immS;
                dec.memWrite  = 1'b1;
            end
            opBranch: begin
                dec.aluOp    = aluSub;
                dec.imm      = immB;
                dec.branch   = 1'b1;
                dec.branchNe = instr_i.bView.funct3[0];  // bne
            end
            opJal: begin
                dec.imm       = immJ;
                dec.jump      = 1'b1;
                dec.regWrite  = 1'b1;
                dec.resultSrc = resPc4;
            end
            opJalr: begin
                dec.aluSrcImm = 1'b1;
                dec.imm       = immI;
                dec.jump      = 1'b1;
                dec.jalr      = 1'b1;
                dec.regWrite  = 1'b1;
                dec.resultSrc = resPc4;
            end
            default: known = 1'b0;  // becomes a bubble
        endcase
        dec.regWrite = dec.regWrite && (dec.rd != 5'd0);
        dec.valid    = instrValid_i && known;
    end

    // flush beats enable
    always_ff @(posedge clk) begin
        if (reset_i || decodeFlush_i) begin
            validQ <= 1'b0;
        end else if (decodeEnable_i) begin
            validQ <= dec.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (decodeEnable_i) begin
            payloadQ <= dec;
        end
    end

    always_comb begin
        idEx_o       = payloadQ;
        idEx_o.valid = validQ;
    end

endmodule

// File: source/aluCore.sv
`timescale 1ns/1ps

module aluCore (
    input  riscvPkg::aluOpE           op_i,
    input  logic [riscvPkg::xlen-1:0] srcA_i,
    input  logic [riscvPkg::xlen-1:0] srcB_i,
    output logic [riscvPkg::xlen-1:0] result_o,
    output logic                      zero_o
);
    import riscvPkg::*;

    logic [4:0] shamt;

    assign shamt = srcB_i[4:0];

    always_comb begin
        case (op_i)
            aluAdd: result_o = srcA_i + srcB_i;
            aluSub: result_o = srcA_i - srcB_i;
            aluAnd: result_o = srcA_i & srcB_i;
            aluOr:  result_o = srcA_i | srcB_i;
            aluXor: result_o = srcA_i ^ srcB_i;
            aluSlt: begin
                result_o = {{(xlen-1){1'b0}}, $signed(srcA_i) < $signed(srcB_i)};
            end
            aluSltu: begin
                result_o = {{(xlen-1){1'b0}}, srcA_i < srcB_i};
            end
            aluSll: result_o = srcA_i << shamt;
            aluSrl: result_o = srcA_i >> shamt;
            aluSra: result_o = $unsigned($signed(srcA_i) >>> shamt);
            default: result_o = '0;
        endcase
    end

    // used by beq/bne after a subtract
    assign zero_o = (result_o == '0);

endmodule

// File: source/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic [4:0]                rs1_i,
    input  logic [4:0]                rs2_i,
    input  riscvPkg::wbPortT          wr_i,
    output logic [riscvPkg::xlen-1:0] rs1Data_o,
    output logic [riscvPkg::xlen-1:0] rs2Data_o,
    output logic [riscvPkg::xlen-1:0] a0_o
);
    import riscvPkg::*;

    logic [xlen-1:0] regs [1:31];  // no storage for x0

    // write-through so decode sees the value being written back
    function automatic logic [xlen-1:0] readReg(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (wr_i.valid && wr_i.rd == addr) begin
            return wr_i.data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.valid && wr_i.rd != 5'd0) begin
            regs[wr_i.rd] <= wr_i.data;
        end
    end

    always_comb begin
        rs1Data_o = readReg(rs1_i);
        rs2Data_o = readReg(rs2_i);
    end

    assign a0_o = regs[10];

    // x0 stays zero even while writeback targets it
    x0ReadsZero: assert property (@(posedge clk) disable iff (reset_i)
        (rs1_i != 5'd0 || rs1Data_o == '0) && (rs2_i != 5'd0 || rs2Data_o == '0))
        else $error("x0 read returned nonzero");

endmodule

// File: source/riscvPkg.sv
package riscvPkg;

    localparam int xlen = 32;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;   // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;   // imm[4:0]
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] immMid;  // imm[10:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLo;   // imm[4:1]
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef union packed {
        rTypeT rView;
        iTypeT iView;
        sTypeT sView;
        bTypeT bView;
    } instrWordT;

    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluSlt, aluSltu, aluSll, aluSrl, aluSra
    } aluOpE;

    typedef enum logic [1:0] {
        resAlu, resMem, resPc4
    } resultSrcE;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1Data;
        logic [xlen-1:0] rs2Data;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [xlen-1:0] imm;
        aluOpE           aluOp;
        logic            aluSrcImm;
        logic            regWrite;
        logic            memWrite;
        resultSrcE       resultSrc;
        logic            branch;
        logic            branchNe;
        logic            jump;
        logic            jalr;
    } idExT;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] aluResult;
        logic [xlen-1:0] storeData;
        logic [4:0]      rd;
        logic            regWrite;
        logic            memWrite;
        resultSrcE       resultSrc;
        logic [xlen-1:0] pcPlus4;
    } exMemT;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } wbPortT;

endpackage
